/* source/ooo_macros.svh */
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// datapath width of every operand and result
`define XLEN        16

// rename tag width, 32 tags in flight at most
`define TAG_LEN     5

// reservation station depth
`define RS_ENTRIES  8

`define MUL_STEPS   `XLEN   // one shift-add step per multiplier bit

// one wakeup lane per functional unit
`define NUM_LANES   2

`endif

/* source/isa_pkg.sv */
`default_nettype none

`include "ooo_macros.svh"

package isa_pkg;

    // opcode carried from dispatch down to the functional units
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,  // a + b
        OP_SUB = 3'd1,  // a - b
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4   // goes to the iterative multiplier
    } alu_op_e;

endpackage

`default_nettype wire

/* source/sched_pkg.sv */
`default_nettype none

`include "ooo_macros.svh"

package sched_pkg;

    // multiplier sequencing
    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_RUN  = 2'd1,    // shift-add iterations in progress
        MUL_DONE = 2'd2     // result on the lane for one cycle
    } mul_state_e;

    // position of each unit inside the wakeup lane vectors
    typedef enum logic [$clog2(`NUM_LANES)-1:0] {LANE_ALU = 0, LANE_MUL = 1} lane_e;

endpackage

`default_nettype wire

/* source/reservation_station.sv */
`default_nettype none

`include "ooo_macros.svh"

module reservation_station import isa_pkg::*, sched_pkg::*; (
    input  logic                                clk,
    input  logic                                reset,
    // dispatch side
    input  logic                                load,
    input  alu_op_e                             op,
    input  logic [`TAG_LEN-1:0]                 dst_tag,
    input  logic [`TAG_LEN-1:0]                 src1_tag,
    input  logic                                src1_ready,
    input  logic [`XLEN-1:0]                    src1_value,
    input  logic [`TAG_LEN-1:0]                 src2_tag,
    input  logic                                src2_ready,
    input  logic [`XLEN-1:0]                    src2_value,
    // result broadcast from the units
    input  logic [`NUM_LANES-1:0]               wake_valid,
    input  logic [`NUM_LANES-1:0][`TAG_LEN-1:0] wake_tag,
    input  logic [`NUM_LANES-1:0][`XLEN-1:0]    wake_value,
    // from issue unit
    input  logic                                clear,
    input  logic [`TAG_LEN-1:0]                 clear_tag,
    output logic                                cand_valid,
    output alu_op_e                             cand_op,
    output logic [`TAG_LEN-1:0]                 cand_dst,
    output logic [`XLEN-1:0]                    cand_a,
    output logic [`XLEN-1:0]                    cand_b,
    output logic                                full
);

    localparam int TOP   = `RS_ENTRIES - 1;    // new entries enter here
    localparam int IDX_W = $clog2(`RS_ENTRIES);

    // current queue, slot 0 holds the oldest entry
    logic [`RS_ENTRIES-1:0] q_valid;
    alu_op_e                q_op   [`RS_ENTRIES];
    logic [`TAG_LEN-1:0]    q_dst  [`RS_ENTRIES];
    logic [`TAG_LEN-1:0]    q_tag1 [`RS_ENTRIES];
    logic [`TAG_LEN-1:0]    q_tag2 [`RS_ENTRIES];
    logic                   q_rdy1 [`RS_ENTRIES];
    logic                   q_rdy2 [`RS_ENTRIES];
    logic [`XLEN-1:0]       q_val1 [`RS_ENTRIES];
    logic [`XLEN-1:0]       q_val2 [`RS_ENTRIES];

    // next-state queue
    logic [`RS_ENTRIES-1:0] n_valid;
    alu_op_e                n_op   [`RS_ENTRIES];
    logic [`TAG_LEN-1:0]    n_dst  [`RS_ENTRIES];
    logic [`TAG_LEN-1:0]    n_tag1 [`RS_ENTRIES];
    logic [`TAG_LEN-1:0]    n_tag2 [`RS_ENTRIES];
    logic                   n_rdy1 [`RS_ENTRIES];
    logic                   n_rdy2 [`RS_ENTRIES];
    logic [`XLEN-1:0]       n_val1 [`RS_ENTRIES];
    logic [`XLEN-1:0]       n_val2 [`RS_ENTRIES];

    logic                   sel_found;  // some entry has both operands
    logic [IDX_W-1:0]       sel_idx;    // lowest such slot

    always_comb begin
        lane_e ln;
        logic  hole;
        n_valid = q_valid;
        n_op    = q_op;
        n_dst   = q_dst;
        n_tag1  = q_tag1;
        n_tag2  = q_tag2;
        n_rdy1  = q_rdy1;
        n_rdy2  = q_rdy2;
        n_val1  = q_val1;
        n_val2  = q_val2;
        // insert, dispatcher guarantees the top slot is free
        if (load) begin
            n_valid[TOP] = 1'b1;
            n_op[TOP]    = op;
            n_dst[TOP]   = dst_tag;
            n_tag1[TOP]  = src1_tag;
            n_rdy1[TOP]  = src1_ready;
            n_val1[TOP]  = src1_value;
            n_tag2[TOP]  = src2_tag;
            n_rdy2[TOP]  = src2_ready;
            n_val2[TOP]  = src2_value;
        end
        // drop the instruction the issue unit just sent
        if (clear) begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (n_valid[i] && n_dst[i] == clear_tag)
                    n_valid[i] = 1'b0;
            end
        end
        // operand capture, also covers forwarding into the entry loaded this cycle
        for (int k = 0; k < `NUM_LANES; k++) begin
            ln = lane_e'(k);
            if (wake_valid[ln]) begin
                for (int i = 0; i < `RS_ENTRIES; i++) begin
                    if (n_valid[i] && !n_rdy1[i] && n_tag1[i] == wake_tag[ln]) begin
                        n_rdy1[i] = 1'b1;
                        n_val1[i] = wake_value[ln];
                    end
                    if (n_valid[i] && !n_rdy2[i] && n_tag2[i] == wake_tag[ln]) begin
                        n_rdy2[i] = 1'b1;
                        n_val2[i] = wake_value[ln];
                    end
                end
            end
        end
        // compaction: everything above the lowest hole moves down one slot
        hole = 1'b0;
        for (int i = 0; i < TOP; i++) begin
            hole = hole | !n_valid[i];  // slot i still holds its pre-shift value here
            if (hole) begin
                n_valid[i] = n_valid[i+1];
                n_op[i]    = n_op[i+1];
                n_dst[i]   = n_dst[i+1];
                n_tag1[i]  = n_tag1[i+1];
                n_rdy1[i]  = n_rdy1[i+1];
                n_val1[i]  = n_val1[i+1];
                n_tag2[i]  = n_tag2[i+1];
                n_rdy2[i]  = n_rdy2[i+1];
                n_val2[i]  = n_val2[i+1];
            end
        end
        if (hole)
            n_valid[TOP] = 1'b0;    // top slot moved down
    end

    // oldest ready entry, lowest index wins
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = TOP; i >= 0; i--) begin
            if (n_valid[i] && n_rdy1[i] && n_rdy2[i]) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            q_valid    <= '0;
            cand_valid <= 1'b0;
        end else begin
            q_valid    <= n_valid;
            cand_valid <= sel_found;
        end
    end

    always_ff @(posedge clk) begin
        q_op     <= n_op;
        q_dst    <= n_dst;
        q_tag1   <= n_tag1;
        q_tag2   <= n_tag2;
        q_rdy1   <= n_rdy1;
        q_rdy2   <= n_rdy2;
        q_val1   <= n_val1;
        q_val2   <= n_val2;
        cand_op  <= n_op[sel_idx];
        cand_dst <= n_dst[sel_idx];
        cand_a   <= n_val1[sel_idx];
        cand_b   <= n_val2[sel_idx];
    end

    assign full = n_valid[TOP];    // no room for a load next cycle

endmodule

`default_nettype wire

/* source/issue_unit.sv */
`default_nettype none

`include "ooo_macros.svh"

module issue_unit import isa_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    // registered candidate from the station
    input  logic                cand_valid,
    input  alu_op_e             cand_op,
    input  logic [`TAG_LEN-1:0] cand_dst,
    input  logic [`XLEN-1:0]    cand_a,
    input  logic [`XLEN-1:0]    cand_b,
    input  logic                mul_busy,
    output logic                clear,
    output logic [`TAG_LEN-1:0] clear_tag,
    output logic                alu_start,
    output logic                mul_start,
    // operands shared by both units
    output alu_op_e             fu_op,
    output logic [`XLEN-1:0]    fu_a,
    output logic [`XLEN-1:0]    fu_b,
    output logic [`TAG_LEN-1:0] fu_dst
);

    logic is_mul;
    logic mul_free;
    logic mul_pending;  // start sent last cycle, busy not up yet

    assign is_mul   = (cand_op == OP_MUL);
    assign mul_free = !mul_busy && !mul_pending;

    // a multiply waiting on the unit blocks everything behind it
    assign alu_start = cand_valid && !is_mul;
    assign mul_start = cand_valid && is_mul && mul_free;

    assign clear     = alu_start || mul_start;
    assign clear_tag = cand_dst;

    assign fu_op  = cand_op;
    assign fu_a   = cand_a;
    assign fu_b   = cand_b;
    assign fu_dst = cand_dst;

    always_ff @(posedge clk) begin
        if (reset)
            mul_pending <= 1'b0;
        else
            mul_pending <= mul_start;   // covers the edge where busy rises
    end

endmodule

`default_nettype wire

/* source/alu_unit.sv */
`default_nettype none

`include "ooo_macros.svh"

module alu_unit import isa_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  alu_op_e             op,
    input  logic [`XLEN-1:0]    a,
    input  logic [`XLEN-1:0]    b,
    input  logic [`TAG_LEN-1:0] dst,
    output logic                done,       // ALU wakeup lane
    output logic [`TAG_LEN-1:0] done_tag,
    output logic [`XLEN-1:0]    done_value
);

    logic [`XLEN-1:0] result;

    always_comb begin
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_XOR:  result = a ^ b;
            default: result = '0;   // multiply never steered here
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            done <= 1'b0;
        else
            done <= start;  // one cycle latency
    end

    always_ff @(posedge clk) begin
        if (start) begin
            done_tag   <= dst;
            done_value <= result;
        end
    end

endmodule

`default_nettype wire

/* source/mul_unit.sv */
`default_nettype none

`include "ooo_macros.svh"

module mul_unit import sched_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [`XLEN-1:0]    a,
    input  logic [`XLEN-1:0]    b,
    input  logic [`TAG_LEN-1:0] dst,
    output logic                busy,
    output logic                done,       // MUL wakeup lane
    output logic [`TAG_LEN-1:0] done_tag,
    output logic [`XLEN-1:0]    done_value
);

    localparam int CNT_W = $clog2(`MUL_STEPS);

    mul_state_e       state;
    logic [CNT_W-1:0] step;
    logic             accept;   // new operands taken this cycle
    logic [`XLEN-1:0] acc;      // partial product, low bits only
    logic [`XLEN-1:0] mcand;
    logic [`XLEN-1:0] mplier;
    logic [`TAG_LEN-1:0] tag_q;

    assign accept = start && (state != MUL_RUN);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= MUL_IDLE;
            step  <= '0;
        end else begin
            case (state)
                MUL_IDLE: begin
                    if (accept)
                        state <= MUL_RUN;
                    step <= '0;
                end
                MUL_RUN: begin
                    step <= step + 1'b1;
                    if (step == CNT_W'(`MUL_STEPS - 1))
                        state <= MUL_DONE;  // last iteration this edge
                end
                MUL_DONE: begin
                    state <= accept ? MUL_RUN : MUL_IDLE;   // back-to-back start allowed
                    step  <= '0;
                end
                default: state <= MUL_IDLE;
            endcase
        end
    end

    // shift-add datapath
    always_ff @(posedge clk) begin
        if (accept) begin
            acc    <= '0;
            mcand  <= a;
            mplier <= b;
            tag_q  <= dst;
        end else if (state == MUL_RUN) begin
            if (mplier[0])
                acc <= acc + mcand;     // carries past XLEN are dropped
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign busy       = (state == MUL_RUN);
    assign done       = (state == MUL_DONE);
    assign done_tag   = tag_q;
    assign done_value = acc;

endmodule

`default_nettype wire

/* source/exec_cluster.sv */
`default_nettype none

`include "ooo_macros.svh"

module exec_cluster import isa_pkg::*, sched_pkg::*; (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                load,
    input  alu_op_e                             op,
    input  logic [`TAG_LEN-1:0]                 dst_tag,
    input  logic [`TAG_LEN-1:0]                 src1_tag,
    input  logic                                src1_ready,
    input  logic [`XLEN-1:0]                    src1_value,
    input  logic [`TAG_LEN-1:0]                 src2_tag,
    input  logic                                src2_ready,
    input  logic [`XLEN-1:0]                    src2_value,
    output logic                                full,
    // completion lanes, indexed by lane_e
    output logic [`NUM_LANES-1:0]               wake_valid,
    output logic [`NUM_LANES-1:0][`TAG_LEN-1:0] wake_tag,
    output logic [`NUM_LANES-1:0][`XLEN-1:0]    wake_value
);

    // station to issue
    logic                cand_valid;
    alu_op_e             cand_op;
    logic [`TAG_LEN-1:0] cand_dst;
    logic [`XLEN-1:0]    cand_a;
    logic [`XLEN-1:0]    cand_b;
    logic                clear;
    logic [`TAG_LEN-1:0] clear_tag;
    // issue to units
    logic                alu_start;
    logic                mul_start;
    logic                mul_busy;
    alu_op_e             fu_op;
    logic [`XLEN-1:0]    fu_a;
    logic [`XLEN-1:0]    fu_b;
    logic [`TAG_LEN-1:0] fu_dst;

    reservation_station u_rs (
        .clk, .reset, .load, .op, .dst_tag,
        .src1_tag, .src1_ready, .src1_value,
        .src2_tag, .src2_ready, .src2_value,
        .wake_valid, .wake_tag, .wake_value,
        .clear, .clear_tag,
        .cand_valid, .cand_op, .cand_dst, .cand_a, .cand_b,
        .full
    );

    issue_unit u_issue (
        .clk, .reset,
        .cand_valid, .cand_op, .cand_dst, .cand_a, .cand_b,
        .mul_busy,
        .clear, .clear_tag, .alu_start, .mul_start,
        .fu_op, .fu_a, .fu_b, .fu_dst
    );

    alu_unit u_alu (
        .clk, .reset,
        .start      (alu_start),
        .op         (fu_op),
        .a          (fu_a),
        .b          (fu_b),
        .dst        (fu_dst),
        .done       (wake_valid[LANE_ALU]),
        .done_tag   (wake_tag[LANE_ALU]),
        .done_value (wake_value[LANE_ALU])
    );

    mul_unit u_mul (
        .clk, .reset,
        .start      (mul_start),
        .a          (fu_a),
        .b          (fu_b),
        .dst        (fu_dst),
        .busy       (mul_busy),
        .done       (wake_valid[LANE_MUL]),
        .done_tag   (wake_tag[LANE_MUL]),
        .done_value (wake_value[LANE_MUL])
    );

endmodule

`default_nettype wire

/* tb/exec_cluster_assert.sv */
`default_nettype none

`include "ooo_macros.svh"

module exec_cluster_assert import sched_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load,
    input  logic                  full,
    input  logic                  clear,
    input  logic [`TAG_LEN-1:0]   clear_tag,
    input  logic                  cand_valid,
    input  logic [`TAG_LEN-1:0]   cand_dst,
    input  logic                  alu_start,
    input  logic                  mul_start,
    input  logic                  mul_busy,
    input  mul_state_e            mul_state,    // multiplier FSM state
    input  logic [`NUM_LANES-1:0] wake_valid
);

    int violations = 0;     // failed properties so far

    // full means the top slot is taken after this edge so no load in the next cycle
    no_load_when_full: assert property (@(posedge clk) disable iff (reset) full |=> !load)
        else begin
            $error("load arrived while the station was full");
            violations++;
        end

    // the issue unit always clears the candidate it sends
    clear_matches_cand: assert property (@(posedge clk) disable iff (reset)
        clear |-> clear_tag == cand_dst)
        else begin
            $error("clear_tag differs from cand_dst");
            violations++;
        end

    // a cleared instruction is gone from the next registered candidate
    cleared_not_repeated: assert property (@(posedge clk) disable iff (reset)
        clear |=> !(cand_valid && cand_dst == $past(clear_tag)))
        else begin
            $error("cleared instruction came back as the candidate");
            violations++;
        end

    alu_lane_after_start: assert property (@(posedge clk) disable iff (reset)
        wake_valid[LANE_ALU] |-> $past(alu_start))
        else begin
            $error("ALU lane valid without alu_start one cycle earlier");
            violations++;
        end

    mul_start_when_free: assert property (@(posedge clk) disable iff (reset)
        mul_start |-> mul_state != MUL_RUN)
        else begin
            $error("mul_start while the multiplier is running");
            violations++;
        end

    // busy holds for MUL_STEPS cycles and drops as the product reaches the lane
    mul_lane_latency: assert property (@(posedge clk) disable iff (reset)
        mul_start |=> mul_busy [*`MUL_STEPS] ##1 (wake_valid[LANE_MUL] && !mul_busy))
        else begin
            $error("MUL lane valid not MUL_STEPS+1 cycles after mul_start");
            violations++;
        end

endmodule

`default_nettype wire

/* tb/exec_cluster_tb.sv */
`default_nettype none

`include "ooo_macros.svh"

module exec_cluster_tb import isa_pkg::*, sched_pkg::*; ();

    localparam int NTAGS      = 1 << `TAG_LEN;
    localparam int WAIT_LIMIT = 2000;   // cycles for any single wait
    localparam int RANDOM_LEN = 300;

    logic                                clk;
    logic                                reset;
    logic                                load;
    alu_op_e                             op;
    logic [`TAG_LEN-1:0]                 dst_tag;
    logic [`TAG_LEN-1:0]                 src1_tag;
    logic                                src1_ready;
    logic [`XLEN-1:0]                    src1_value;
    logic [`TAG_LEN-1:0]                 src2_tag;
    logic                                src2_ready;
    logic [`XLEN-1:0]                    src2_value;
    logic                                full;
    logic [`NUM_LANES-1:0]               wake_valid;
    logic [`NUM_LANES-1:0][`TAG_LEN-1:0] wake_tag;
    logic [`NUM_LANES-1:0][`XLEN-1:0]    wake_value;

    // scoreboard with one slot per tag
    logic [`XLEN-1:0] exp_val   [NTAGS];
    int               exp_lane  [NTAGS];
    bit               in_flight [NTAGS];
    bit               finished  [NTAGS];    // result seen on a lane
    bit               ever_used [NTAGS];
    int               users     [NTAGS];    // in-flight consumers still naming the tag
    int               pend1     [NTAGS];    // producer the source waited on or -1
    int               pend2     [NTAGS];
    int               free_pool [$];
    int               used_tags [$];
    int               outstanding = 0;

    exec_cluster u_dut (
        .clk, .reset, .load, .op, .dst_tag,
        .src1_tag, .src1_ready, .src1_value,
        .src2_tag, .src2_ready, .src2_value,
        .full, .wake_valid, .wake_tag, .wake_value
    );

    bind exec_cluster exec_cluster_assert u_assert (
        .clk, .reset, .load, .full, .clear, .clear_tag, .cand_valid, .cand_dst,
        .alu_start, .mul_start, .mul_busy,
        .mul_state  (u_mul.state),
        .wake_valid
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [`XLEN-1:0] expected_result(input alu_op_e o,
                                                         input logic [`XLEN-1:0] a,
                                                         input logic [`XLEN-1:0] b);
        logic [2*`XLEN-1:0] product;
        product = a * b;
        case (o)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return product[`XLEN-1:0];     // low half only
            default: return '0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] rand_word();
        logic [31:0] r;
        r = $urandom;
        return r[`XLEN-1:0];
    endfunction

    function automatic alu_op_e rand_op(input int hi);
        return alu_op_e'($urandom_range(hi, 0));    // hi 3 keeps to ALU opcodes
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic release_src(input int p);
        if (p >= 0) begin
            users[p]--;
            if (users[p] == 0 && finished[p])
                free_pool.push_back(p);     // last waiting consumer gone
        end
    endtask

    task automatic retire(input int lane, input logic [`TAG_LEN-1:0] t,
                          input logic [`XLEN-1:0] v);
        if (!in_flight[t])
            abort($sformatf("tag %0d completed on lane %0d but was not in flight", t, lane));
        else begin
            check($sformatf("wake_valid lane of tag %0d", t), lane, exp_lane[t]);
            check($sformatf("wake_value of tag %0d", t), v, exp_val[t]);
            in_flight[t] = 1'b0;
            finished[t]  = 1'b1;
            outstanding--;
            release_src(pend1[t]);
            release_src(pend2[t]);
            if (users[t] == 0)
                free_pool.push_back(t);
        end
    endtask

    // completion checker sampling the lanes at the falling edge where they are stable
    always @(negedge clk) begin
        if (!reset) begin
            if (u_dut.u_assert.violations != 0)
                abort("a protocol assertion failed");
            else begin
                for (int l = 0; l < `NUM_LANES; l++) begin
                    if (wake_valid[l])
                        retire(l, wake_tag[l], wake_value[l]);
                end
            end
        end
    end

    task automatic pick_source(input int p, output logic [`TAG_LEN-1:0] tg, output logic rdy,
                               output logic [`XLEN-1:0] val, output logic [`XLEN-1:0] opnd,
                               output int waits_on);
        tg       = '0;
        rdy      = 1'b1;
        val      = rand_word();
        opnd     = val;
        waits_on = -1;
        if (p >= 0) begin
            tg   = p[`TAG_LEN-1:0];
            opnd = exp_val[p];
            if (finished[p])
                val = exp_val[p];       // producer done so hand over the value
            else begin
                rdy      = 1'b0;        // value field is junk and the station waits for the lane
                waits_on = p;
                users[p]++;
            end
        end
    endtask

    // one load on the next rising edge where p1 and p2 name a producer tag or -1
    task automatic drive(input alu_op_e o, input int p1, input int p2, output int t);
        logic [`TAG_LEN-1:0] tg1;
        logic [`TAG_LEN-1:0] tg2;
        logic                r1;
        logic                r2;
        logic [`XLEN-1:0]    v1;
        logic [`XLEN-1:0]    v2;
        logic [`XLEN-1:0]    a;
        logic [`XLEN-1:0]    b;
        int                  w1;
        int                  w2;
        @(posedge clk);
        pick_source(p1, tg1, r1, v1, a, w1);
        pick_source(p2, tg2, r2, v2, b, w2);
        if (free_pool.size() == 0)
            abort("no free tag left to dispatch with");
        else begin
            t = free_pool.pop_front();
            pend1[t]     = w1;
            pend2[t]     = w2;
            exp_val[t]   = expected_result(o, a, b);
            exp_lane[t]  = (o == OP_MUL) ? int'(LANE_MUL) : int'(LANE_ALU);
            in_flight[t] = 1'b1;
            finished[t]  = 1'b0;
            outstanding++;
            if (!ever_used[t]) begin
                ever_used[t] = 1'b1;
                used_tags.push_back(t);
            end
            load       <= 1'b1;
            op         <= o;
            dst_tag    <= t[`TAG_LEN-1:0];
            src1_tag   <= tg1;
            src1_ready <= r1;
            src1_value <= v1;
            src2_tag   <= tg2;
            src2_ready <= r2;
            src2_value <= v2;
        end
    endtask

    task automatic send(input alu_op_e o, input int p1, input int p2, output int t);
        int waited;
        waited = 0;
        while (free_pool.size() == 0) begin
            @(posedge clk);
            load <= 1'b0;
            waited++;
            if (waited > WAIT_LIMIT)
                abort("timed out waiting for a free tag");
        end
        waited = 0;
        @(negedge clk);
        while (full) begin      // full covers the load still on the port this cycle
            @(posedge clk);
            load <= 1'b0;
            waited++;
            if (waited > WAIT_LIMIT)
                abort("timed out waiting for the station to leave full");
            @(negedge clk);
        end
        drive(o, p1, p2, t);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        load <= 1'b0;
        while (outstanding != 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                abort("timed out waiting for in-flight instructions to complete");
        end
    endtask

    initial begin
        int t;
        int prev;
        int n;
        int p1;
        int p2;
        bit full_seen;
        void'($urandom(32'hff42));
        reset      = 1'b1;
        load       = 1'b0;
        op         = OP_ADD;
        dst_tag    = '0;
        src1_tag   = '0;
        src1_ready = 1'b0;
        src1_value = '0;
        src2_tag   = '0;
        src2_ready = 1'b0;
        src2_value = '0;
        for (int i = 0; i < NTAGS; i++) begin
            users[i]     = 0;
            pend1[i]     = -1;
            pend2[i]     = -1;
            in_flight[i] = 1'b0;
            finished[i]  = 1'b0;
            ever_used[i] = 1'b0;
            free_pool.push_back(i);
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin                        // idle cluster stays quiet
            @(negedge clk);
            check("full", full, 0);
            check("wake_valid", wake_valid, 0);
        end
        for (int i = 0; i < 12; i++)
            send(rand_op(3), -1, -1, t);        // independent ALU work
        drain();
        prev = -1;
        for (int i = 0; i < 10; i++) begin      // chain through src1
            send(rand_op(4), prev, -1, t);
            prev = t;
        end
        drain();
        for (int i = 0; i < 6; i++)
            send(OP_MUL, -1, -1, t);
        drain();
        // multiplies up front stall the pick so ALU loads pile up behind them
        for (int i = 0; i < 3; i++)
            send(OP_MUL, -1, -1, t);
        n = 0;
        full_seen = 1'b0;
        while (!full_seen) begin
            @(negedge clk);
            full_seen = full;
            if (!full_seen)
                drive(rand_op(3), -1, -1, t);
            n++;
            if (n > 64)
                abort("station never reported full");
        end
        drain();
        @(negedge clk);
        check("full", full, 0);
        for (int i = 0; i < RANDOM_LEN; i++) begin
            p1 = -1;
            p2 = -1;
            if (used_tags.size() > 0 && $urandom_range(1, 0) == 1)
                p1 = used_tags[$urandom_range(used_tags.size() - 1, 0)];
            if (used_tags.size() > 0 && $urandom_range(1, 0) == 1)
                p2 = used_tags[$urandom_range(used_tags.size() - 1, 0)];
            send(rand_op(4), p1, p2, t);
        end
        drain();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/isa_pkg.sv
source/sched_pkg.sv
source/reservation_station.sv
source/issue_unit.sv
source/alu_unit.sv
source/mul_unit.sv
source/exec_cluster.sv
tb/exec_cluster_assert.sv
tb/exec_cluster_tb.sv
